/* Bender.yml */
package:
  name: issue_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ooo_pkg.sv
      - hdl/map_table.sv
      - hdl/tag_free_list.sv
      - hdl/reservation_station.sv
      - hdl/alu_unit.sv
      - hdl/issue_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_issue_core.sv

/* dv/tb_issue_core.sv */
`include "ooo_params.svh"

module tb_issue_core;
    import ooo_pkg::*;

    logic      clk;
    logic      reset;
    dispatch_t disp;
    logic      dispatch_valid;
    logic      exec_stall;
    logic      kill;
    logic      resolve;
    logic      dispatch_stall;
    cdb_t      cdb;

    logic [`XLEN-1:0] ref_regs [`NUM_ARCH_REGS];
    cdb_t             seen_cdb [$];
    int               seen_cycle [$];
    int               cycle;
    integer           seed;

    issue_core uut (
        .clk            (clk),
        .reset          (reset),
        .dispatch       (disp),
        .dispatch_valid (dispatch_valid),
        .exec_stall     (exec_stall),
        .kill           (kill),
        .resolve        (resolve),
        .dispatch_stall (dispatch_stall),
        .cdb            (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] sext(input logic [`IMM_W-1:0] imm);
        return {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
    endfunction

    function automatic logic [`IMM_W-1:0] rand_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[`IMM_W-1:0];
    endfunction

    function automatic logic [`XLEN-1:0] alu_ref(input alu_op_e op, input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    // one cycle, cdb logged where it is stable
    task automatic step();
        if (cdb.valid) begin
            seen_cdb.push_back(cdb);
            seen_cycle.push_back(cycle);
        end
        @(posedge clk);
        #1;
        cycle++;
    endtask

    task automatic send(input alu_op_e op, input logic [`AREG_W-1:0] rd,
                        input logic [`AREG_W-1:0] rs1, input logic [`IMM_W-1:0] opb_bits,
                        input logic is_imm, input logic spec);
        int n;
        n = 0;
        while (dispatch_stall) begin
            if (n > 50) begin
                $display("timeout waiting for dispatch_stall to fall");
                $display("Test FAILED");
                $fatal(1, "dispatch wait expired");
            end
            n++;
            step();
        end
        disp.op          = op;
        disp.rd          = rd;
        disp.rs1         = rs1;
        disp.opb.imm     = opb_bits;
        disp.opb_is_imm  = is_imm;
        disp.speculative = spec;
        dispatch_valid   = 1'b1;
        step();
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_cdb(output cdb_t got, output int at);
        int n;
        n = 0;
        while (seen_cdb.size() == 0) begin
            if (n > 100) begin
                $display("timeout waiting for a CDB broadcast");
                $display("Test FAILED");
                $fatal(1, "cdb wait expired");
            end
            n++;
            step();
        end
        got = seen_cdb.pop_front();
        at  = seen_cycle.pop_front();
    endtask

    task automatic check_cdb(input cdb_t got, input logic [`TAG_W-1:0] tag,
                             input logic [`XLEN-1:0] value);
        if (got.tag !== tag || got.value !== value) begin
            $display("ERR %0t: cdb tag %0d value %h, expected tag %0d value %h",
                     $time, got.tag, got.value, tag, value);
            $display("Test FAILED");
            $fatal(1, "cdb mismatch");
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: dispatch_stall %b, expected %b", $time, got, exp);
            $display("Test FAILED");
            $fatal(1, "stall mismatch");
        end
    endtask

    // dispatch rd = rs1 op imm and record the expected value
    task automatic send_imm(input alu_op_e op, input logic [`AREG_W-1:0] rd,
                            input logic [`AREG_W-1:0] rs1, input logic [`IMM_W-1:0] imm,
                            input logic spec, output logic [`XLEN-1:0] exp);
        exp = alu_ref(op, ref_regs[rs1], sext(imm));
        send(op, rd, rs1, imm, 1'b1, spec);
    endtask

    task automatic imm_ops();
        cdb_t             c;
        int               at;
        logic [`XLEN-1:0] exp;
        alu_op_e          ops [6];
        ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL};
        send_imm(ALU_ADD, 1, 0, rand_imm(), 1'b0, exp);
        wait_cdb(c, at);
        check_cdb(c, 1, exp);
        ref_regs[1] = exp;
        for (int k = 0; k < 6; k++) begin
            send_imm(ops[k], 2 + k, 1, rand_imm(), 1'b0, exp);
            wait_cdb(c, at);
            check_cdb(c, 1, exp);
            ref_regs[2 + k] = exp;
        end
        send_imm(ALU_ADD, 9, 6, 0, 1'b0, exp);  // read back r6
        wait_cdb(c, at);
        check_cdb(c, 1, ref_regs[6]);
        ref_regs[9] = exp;
    endtask

    task automatic dep_chain();
        cdb_t             c;
        int               at [3];
        logic [`XLEN-1:0] exp;
        send_imm(ALU_ADD, 1, 0, rand_imm(), 1'b0, exp);
        ref_regs[1] = exp;
        ref_regs[2] = ref_regs[1] + ref_regs[1];
        ref_regs[3] = ref_regs[2] - ref_regs[1];
        send(ALU_ADD, 2, 1, 12'd1, 1'b0, 1'b0);
        send(ALU_SUB, 3, 2, 12'd1, 1'b0, 1'b0);
        for (int k = 0; k < 3; k++) begin
            wait_cdb(c, at[k]);
            check_cdb(c, k + 1, ref_regs[k + 1]);
            if (k > 0 && at[k] - at[k - 1] < 2) begin
                $display("ERR %0t: dependent broadcast only %0d cycles after producer",
                         $time, at[k] - at[k - 1]);
                $display("Test FAILED");
                $fatal(1, "dependency timing");
            end
        end
    endtask

    task automatic oldest_first();
        cdb_t             c;
        int               at;
        int               prev;
        logic [`XLEN-1:0] exp [4];
        exec_stall = 1'b1;
        for (int k = 0; k < 3; k++) begin
            send_imm(ALU_XOR, 4 + k, 0, rand_imm(), 1'b0, exp[k]);
        end
        exec_stall = 1'b0;  // oldest issues, slot 0 frees
        step();
        exec_stall = 1'b1;
        send_imm(ALU_XOR, 7, 0, rand_imm(), 1'b0, exp[3]);  // youngest lands in slot 0
        exec_stall = 1'b0;
        for (int k = 0; k < 4; k++) begin
            wait_cdb(c, at);
            check_cdb(c, k + 1, exp[k]);
            ref_regs[4 + k] = exp[k];
            if (k > 1 && at != prev + 1) begin
                $display("ERR %0t: broadcasts not back to back", $time);
                $display("Test FAILED");
                $fatal(1, "issue order timing");
            end
            prev = at;
        end
    endtask

    task automatic capacity();
        cdb_t             c;
        int               at;
        logic [`XLEN-1:0] exp [8];
        exec_stall = 1'b1;
        for (int k = 0; k < 8; k++) begin
            check_stall(dispatch_stall, 1'b0);
            send_imm(ALU_ADD, 8 + k, 0, rand_imm(), 1'b0, exp[k]);
        end
        check_stall(dispatch_stall, 1'b1);  // station full
        exec_stall = 1'b0;
        for (int k = 0; k < 8; k++) begin
            wait_cdb(c, at);
            check_cdb(c, k + 1, exp[k]);
            ref_regs[8 + k] = exp[k];
        end
        check_stall(dispatch_stall, 1'b0);
    endtask

    task automatic kill_spec();
        cdb_t             c;
        int               at;
        logic [`XLEN-1:0] exp_p;
        exec_stall = 1'b1;
        send_imm(ALU_ADD, 9, 0, rand_imm(), 1'b0, exp_p);
        send(ALU_ADD, 10, 9, rand_imm(), 1'b1, 1'b1);
        send(ALU_XOR, 11, 10, 12'd9, 1'b0, 1'b1);
        kill = 1'b1;
        step();
        kill = 1'b0;
        // tags 2 and 3 come back, so they are reused
        send(ALU_ADD, 12, 10, 12'd0, 1'b1, 1'b0);
        send(ALU_ADD, 13, 11, 12'd0, 1'b1, 1'b0);
        exec_stall = 1'b0;
        wait_cdb(c, at);
        check_cdb(c, 1, exp_p);
        ref_regs[9] = exp_p;
        wait_cdb(c, at);
        check_cdb(c, 2, ref_regs[10]);
        wait_cdb(c, at);
        check_cdb(c, 3, ref_regs[11]);
        ref_regs[12] = ref_regs[10];
        ref_regs[13] = ref_regs[11];
        repeat (10) step();
        if (seen_cdb.size() != 0) begin
            $display("a killed instruction still broadcast on the CDB");
            $display("Test FAILED");
            $fatal(1, "stray broadcast");
        end
    endtask

    task automatic resolve_spec();
        cdb_t             c;
        int               at;
        logic [`XLEN-1:0] exp_p;
        logic [`IMM_W-1:0] imm;
        exec_stall = 1'b1;
        send_imm(ALU_ADD, 14, 0, rand_imm(), 1'b0, exp_p);
        imm = rand_imm();
        send(ALU_SUB, 15, 14, imm, 1'b1, 1'b1);
        resolve = 1'b1;
        step();
        resolve = 1'b0;
        kill = 1'b1;
        step();
        kill = 1'b0;
        exec_stall = 1'b0;
        wait_cdb(c, at);
        check_cdb(c, 1, exp_p);
        ref_regs[14] = exp_p;
        wait_cdb(c, at);
        check_cdb(c, 2, exp_p - sext(imm));
        ref_regs[15] = exp_p - sext(imm);
    endtask

    initial begin
        seed           = 94016;
        cycle          = 0;
        reset          = 1'b1;
        disp           = '0;
        dispatch_valid = 1'b0;
        exec_stall     = 1'b0;
        kill           = 1'b0;
        resolve        = 1'b0;
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_stall(dispatch_stall, 1'b0);
        imm_ops();
        dep_chain();
        oldest_first();
        capacity();
        kill_spec();
        resolve_spec();
        $display("Test OK");
        $finish;
    end

endmodule

/* hdl/alu_unit.sv */
`include "ooo_params.svh"

module alu_unit (
    input  logic            clk,
    input  logic            reset,
    input  ooo_pkg::issue_t issue,
    output ooo_pkg::cdb_t   cdb
);
    import ooo_pkg::*;

    logic [`XLEN-1:0]  result;
    logic              cdb_valid_q;
    logic [`TAG_W-1:0] cdb_tag_q;
    logic [`XLEN-1:0]  cdb_value_q;

    always_comb begin
        case (issue.op)
            ALU_ADD: result = issue.val_a + issue.val_b;
            ALU_SUB: result = issue.val_a - issue.val_b;
            ALU_AND: result = issue.val_a & issue.val_b;
            ALU_OR:  result = issue.val_a | issue.val_b;
            ALU_XOR: result = issue.val_a ^ issue.val_b;
            ALU_SLL: result = issue.val_a << issue.val_b[4:0];  // shamt only
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag_q   <= issue.dest_tag;
        cdb_value_q <= result;
    end

    always_comb begin
        cdb.valid = cdb_valid_q;
        cdb.tag   = cdb_tag_q;
        cdb.value = cdb_value_q;
    end

endmodule

/* hdl/issue_core.sv */
`include "ooo_params.svh"

module issue_core (
    input  logic               clk,
    input  logic               reset,
    input  ooo_pkg::dispatch_t dispatch,
    input  logic               dispatch_valid,
    input  logic               exec_stall,
    input  logic               kill,
    input  logic               resolve,
    output logic               dispatch_stall,
    output ooo_pkg::cdb_t      cdb
);
    import ooo_pkg::*;

    src_t                 rs1_src;
    src_t                 rs2_src;
    src_t                 opb_src;
    rs_entry_t            alloc_entry;
    issue_t               issue;
    logic                 rs_full;
    logic                 tags_empty;
    logic                 accept;
    logic [`TAG_W-1:0]    alloc_tag;
    logic [`NUM_TAGS-1:0] killed_tags;

    assign dispatch_stall = rs_full || tags_empty;
    assign accept         = dispatch_valid && !dispatch_stall;

    always_comb begin
        if (dispatch.opb_is_imm) begin
            opb_src.tag   = '0;
            opb_src.value = {{(`XLEN-`IMM_W){dispatch.opb.imm[`IMM_W-1]}}, dispatch.opb.imm};
            opb_src.ready = 1'b1;
        end else begin
            opb_src = rs2_src;
        end
        alloc_entry.valid       = 1'b1;
        alloc_entry.speculative = dispatch.speculative;
        alloc_entry.op          = dispatch.op;
        alloc_entry.dest_tag    = alloc_tag;
        alloc_entry.src_a       = rs1_src;
        alloc_entry.src_b       = opb_src;
        alloc_entry.birthday    = '0;  // stamped in the station
    end

    map_table u_map_table (
        .clk     (clk),
        .reset   (reset),
        .rd_we   (accept),
        .rd_idx  (dispatch.rd),
        .rd_tag  (alloc_tag),
        .rd_spec (dispatch.speculative),
        .rs1_idx (dispatch.rs1),
        .rs2_idx (dispatch.opb.rs2.idx),
        .cdb     (cdb),
        .kill    (kill),
        .resolve (resolve),
        .rs1_src (rs1_src),
        .rs2_src (rs2_src)
    );

    tag_free_list u_tag_free_list (
        .clk         (clk),
        .reset       (reset),
        .alloc       (accept),
        .cdb         (cdb),
        .killed_tags (killed_tags),
        .alloc_tag   (alloc_tag),
        .empty       (tags_empty)
    );

    reservation_station u_rs (
        .clk          (clk),
        .reset        (reset),
        .alloc_enable (accept),
        .alloc_entry  (alloc_entry),
        .cdb          (cdb),
        .exec_stall   (exec_stall),
        .kill         (kill),
        .resolve      (resolve),
        .rs_full      (rs_full),
        .issue        (issue),
        .killed_tags  (killed_tags)
    );

    alu_unit u_alu (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

/* hdl/map_table.sv */
`include "ooo_params.svh"

module map_table (
    input  logic                clk,
    input  logic                reset,
    input  logic                rd_we,
    input  logic [`AREG_W-1:0]  rd_idx,
    input  logic [`TAG_W-1:0]   rd_tag,
    input  logic                rd_spec,
    input  logic [`AREG_W-1:0]  rs1_idx,
    input  logic [`AREG_W-1:0]  rs2_idx,
    input  ooo_pkg::cdb_t       cdb,
    input  logic                kill,
    input  logic                resolve,
    output ooo_pkg::src_t       rs1_src,
    output ooo_pkg::src_t       rs2_src
);
    import ooo_pkg::*;

    logic [`XLEN-1:0]          reg_value [`NUM_ARCH_REGS];
    logic [`TAG_W-1:0]         reg_tag   [`NUM_ARCH_REGS];
    logic [`NUM_ARCH_REGS-1:0] reg_ready;
    logic [`NUM_ARCH_REGS-1:0] reg_spec;

    // read with same-cycle cdb forwarding
    function automatic src_t lookup(input logic [`AREG_W-1:0] idx);
        src_t src;
        logic hit;
        hit       = cdb.valid && (reg_tag[idx] != '0) && (cdb.tag == reg_tag[idx]);
        src.tag   = reg_tag[idx];
        src.value = hit ? cdb.value : reg_value[idx];
        src.ready = reg_ready[idx] || (reg_tag[idx] == '0) || hit;
        return src;
    endfunction

    always_comb begin
        rs1_src = lookup(rs1_idx);
        rs2_src = lookup(rs2_idx);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                reg_value[i] <= '0;
                reg_tag[i]   <= '0;
            end
            reg_ready <= '1;
            reg_spec  <= '0;
        end else begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                if (cdb.valid && (reg_tag[i] != '0) && (reg_tag[i] == cdb.tag)) begin
                    reg_value[i] <= cdb.value;
                    reg_tag[i]   <= '0;  // producer done
                    reg_ready[i] <= 1'b1;
                end
                // roll back to the last written value
                if (kill && reg_spec[i]) begin
                    reg_tag[i]   <= '0;
                    reg_ready[i] <= 1'b1;
                end
                if (kill || resolve) begin
                    reg_spec[i] <= 1'b0;
                end
            end
            // rename wins over kill and write-back
            if (rd_we) begin
                reg_tag[rd_idx]   <= rd_tag;
                reg_ready[rd_idx] <= 1'b0;
                reg_spec[rd_idx]  <= rd_spec;
            end
        end
    end

endmodule

/* hdl/ooo_params.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// architectural register file
`define NUM_ARCH_REGS 16
`define AREG_W        4

// destination tags, tag 0 means no producer
`define NUM_TAGS      16
`define TAG_W         4

`define RS_DEPTH      8
`define XLEN          32
`define AGE_W         8  // birthday counter width
`define IMM_W         12

`endif

/* hdl/ooo_pkg.sv */
`include "ooo_params.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic [`IMM_W-`AREG_W-1:0] pad;  // zero
        logic [`AREG_W-1:0]        idx;
    } opb_reg_t;

    // operand b is a register index or an immediate, chosen by opb_is_imm
    typedef union packed {
        opb_reg_t          rs2;
        logic [`IMM_W-1:0] imm;
    } opb_u;

    typedef struct packed {
        alu_op_e            op;
        logic [`AREG_W-1:0] rd;
        logic [`AREG_W-1:0] rs1;
        opb_u               opb;
        logic               opb_is_imm;
        logic               speculative;
    } dispatch_t;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  value;
        logic              ready;
    } src_t;

    typedef struct packed {
        logic              valid;
        logic              speculative;
        alu_op_e           op;
        logic [`TAG_W-1:0] dest_tag;
        src_t              src_a;
        src_t              src_b;
        logic [`AGE_W-1:0] birthday;
    } rs_entry_t;

    typedef struct packed {
        logic              valid;
        alu_op_e           op;
        logic [`TAG_W-1:0] dest_tag;
        logic [`XLEN-1:0]  val_a;
        logic [`XLEN-1:0]  val_b;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  value;
    } cdb_t;

endpackage

/* hdl/reservation_station.sv */
`include "ooo_params.svh"

module reservation_station (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc_enable,
    input  ooo_pkg::rs_entry_t   alloc_entry,
    input  ooo_pkg::cdb_t        cdb,
    input  logic                 exec_stall,
    input  logic                 kill,
    input  logic                 resolve,
    output logic                 rs_full,
    output ooo_pkg::issue_t      issue,
    output logic [`NUM_TAGS-1:0] killed_tags
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    rs_entry_t            slots [`RS_DEPTH];
    rs_entry_t            new_entry;
    logic [`AGE_W-1:0]    birth_ctr;
    logic [`RS_DEPTH-1:0] entry_ready;
    logic [`RS_DEPTH-1:0] flush;
    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     sel_idx;
    logic                 found_free;
    logic                 found_ready;
    logic [`AGE_W-1:0]    age;
    logic [`AGE_W-1:0]    best_age;

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entry_ready[i] = slots[i].valid && slots[i].src_a.ready && slots[i].src_b.ready;
        end
    end

    // lowest free slot
    always_comb begin
        found_free = 1'b0;
        free_idx   = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!slots[i].valid) begin
                found_free = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    assign rs_full = !found_free;

    // oldest ready entry, age taken modulo the counter width
    always_comb begin
        found_ready = 1'b0;
        sel_idx     = '0;
        best_age    = '0;
        age         = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            age = birth_ctr - slots[i].birthday;
            if (entry_ready[i] && (!found_ready || age > best_age)) begin
                found_ready = 1'b1;
                sel_idx     = IDX_W'(i);
                best_age    = age;
            end
        end
    end

    always_comb begin
        issue.valid    = found_ready && !exec_stall;
        issue.op       = slots[sel_idx].op;
        issue.dest_tag = slots[sel_idx].dest_tag;
        issue.val_a    = slots[sel_idx].src_a.value;
        issue.val_b    = slots[sel_idx].src_b.value;
    end

    // an entry issuing this cycle escapes the kill
    always_comb begin
        killed_tags = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            flush[i] = kill && slots[i].valid && slots[i].speculative
                       && !(issue.valid && (sel_idx == IDX_W'(i)));
            if (flush[i]) begin
                killed_tags[slots[i].dest_tag] = 1'b1;
            end
        end
    end

    always_comb begin
        new_entry          = alloc_entry;
        new_entry.valid    = 1'b1;
        new_entry.birthday = birth_ctr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                slots[i].valid       <= 1'b0;
                slots[i].speculative <= 1'b0;
            end
            birth_ctr <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                // wakeup, both sources independently
                if (cdb.valid && slots[i].valid) begin
                    if (!slots[i].src_a.ready && (slots[i].src_a.tag == cdb.tag)) begin
                        slots[i].src_a.value <= cdb.value;
                        slots[i].src_a.ready <= 1'b1;
                    end
                    if (!slots[i].src_b.ready && (slots[i].src_b.tag == cdb.tag)) begin
                        slots[i].src_b.value <= cdb.value;
                        slots[i].src_b.ready <= 1'b1;
                    end
                end
                if (resolve) begin
                    slots[i].speculative <= 1'b0;
                end
                if (flush[i]) begin
                    slots[i].valid <= 1'b0;
                end
            end
            if (issue.valid) begin
                slots[sel_idx].valid <= 1'b0;
            end
            if (alloc_enable && found_free) begin
                slots[free_idx] <= new_entry;
                birth_ctr       <= birth_ctr + 1'b1;
            end
        end
    end

endmodule

/* hdl/tag_free_list.sv */
`include "ooo_params.svh"

module tag_free_list (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc,
    input  ooo_pkg::cdb_t        cdb,
    input  logic [`NUM_TAGS-1:0] killed_tags,
    output logic [`TAG_W-1:0]    alloc_tag,
    output logic                 empty
);

    logic [`NUM_TAGS-1:0] busy;
    logic [`NUM_TAGS-1:0] busy_next;

    // lowest free tag, 0 never handed out
    always_comb begin
        alloc_tag = '0;
        for (int i = `NUM_TAGS - 1; i >= 1; i--) begin
            if (!busy[i]) begin
                alloc_tag = i[`TAG_W-1:0];
            end
        end
    end

    assign empty = &busy[`NUM_TAGS-1:1];

    always_comb begin
        busy_next = busy & ~killed_tags;
        if (cdb.valid) begin
            busy_next[cdb.tag] = 1'b0;
        end
        if (alloc && !empty) begin
            busy_next[alloc_tag] = 1'b1;
        end
        busy_next[0] = 1'b1;  // reserved
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= `NUM_TAGS'(1);
        end else begin
            busy <= busy_next;
        end
    end

endmodule

/* src.f */
+incdir+hdl
hdl/ooo_pkg.sv
hdl/map_table.sv
hdl/tag_free_list.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/issue_core.sv
dv/tb_issue_core.sv
